// File: hw/wb_pkg.sv
// shared widths, write-select bit positions and register count for write-back
package wb_pkg;

  // datapath widths
  localparam int xlen       = 64;
  localparam int inst_w     = 32;
  localparam int reg_addr_w = 5;

  // architectural register file size, x0 included
  localparam int reg_count  = 32;

  // one-hot write-source select
  localparam int sel_w      = 3;
  localparam int sel_exe    = 0;
  localparam int sel_mem    = 1;
  localparam int sel_csr    = 2;

  // serial port character
  localparam int char_w     = 8;

  // retired instruction counter
  localparam int cnt_w      = 64;

endpackage

// File: hw/wb_latch.sv
// write-back pipeline register with valid flag, allowin and retire decision
`timescale 1ns/10ps

module wb_latch (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [wb_pkg::xlen-1:0]       in_pc,
  input  logic [wb_pkg::inst_w-1:0]     in_inst,
  input  logic                          in_wen,
  input  logic [wb_pkg::reg_addr_w-1:0] in_wdest,
  input  logic [wb_pkg::sel_w-1:0]      in_wr_sel,
  input  logic [wb_pkg::xlen-1:0]       in_ex_data,
  input  logic [wb_pkg::xlen-1:0]       in_mem_data,
  input  logic [wb_pkg::xlen-1:0]       in_csr_data,
  input  logic                          in_uart_valid,
  input  logic [wb_pkg::char_w-1:0]     in_uart_char,
  input  logic                          uart_ready,
  output logic                          allowin,
  output logic                          held_valid,
  output logic                          retire,
  output logic [wb_pkg::xlen-1:0]       held_pc,
  output logic [wb_pkg::inst_w-1:0]     held_inst,
  output logic                          held_wen,
  output logic [wb_pkg::reg_addr_w-1:0] held_wdest,
  output logic [wb_pkg::sel_w-1:0]      held_wr_sel,
  output logic [wb_pkg::xlen-1:0]       held_ex_data,
  output logic [wb_pkg::xlen-1:0]       held_mem_data,
  output logic [wb_pkg::xlen-1:0]       held_csr_data,
  output logic                          held_uart_valid,
  output logic [wb_pkg::char_w-1:0]     held_uart_char
);

  // a character waits for the sink, everything else retires at once
  assign retire  = held_valid && (!held_uart_valid || uart_ready);
  assign allowin = !held_valid || retire;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid <= 1'b0;
    end else if (allowin) begin
      held_valid <= in_valid;
    end
  end

  // item fields load only on acceptance
  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      held_pc         <= in_pc;
      held_inst       <= in_inst;
      held_wen        <= in_wen;
      held_wdest      <= in_wdest;
      held_wr_sel     <= in_wr_sel;
      held_ex_data    <= in_ex_data;
      held_mem_data   <= in_mem_data;
      held_csr_data   <= in_csr_data;
      held_uart_valid <= in_uart_valid;
      held_uart_char  <= in_uart_char;
    end
  end

  // stalled item keeps its whole record until it retires
  a_held_stable: assert property (@(posedge clk) disable iff (rst)
    held_valid && !retire |=> held_valid && $stable(held_pc) && $stable(held_inst)
      && $stable(held_wen) && $stable(held_wdest) && $stable(held_wr_sel)
      && $stable(held_ex_data) && $stable(held_mem_data) && $stable(held_csr_data)
      && $stable(held_uart_valid) && $stable(held_uart_char));

endmodule

// File: hw/wb_select.sv
// one-hot write-source mux and register write qualification
`timescale 1ns/10ps

module wb_select (
  input  logic                          held_wen,
  input  logic [wb_pkg::reg_addr_w-1:0] held_wdest,
  input  logic [wb_pkg::sel_w-1:0]      held_wr_sel,
  input  logic [wb_pkg::xlen-1:0]       held_ex_data,
  input  logic [wb_pkg::xlen-1:0]       held_mem_data,
  input  logic [wb_pkg::xlen-1:0]       held_csr_data,
  input  logic                          retire,
  output logic                          wr_en,
  output logic [wb_pkg::reg_addr_w-1:0] wr_addr,
  output logic [wb_pkg::xlen-1:0]       wr_data
);

  logic sel_exe_bit;
  logic sel_mem_bit;
  logic sel_csr_bit;

  assign sel_exe_bit = held_wr_sel[wb_pkg::sel_exe];
  assign sel_mem_bit = held_wr_sel[wb_pkg::sel_mem];
  assign sel_csr_bit = held_wr_sel[wb_pkg::sel_csr];

  // and-or mux, empty select gives zero
  assign wr_data = ({wb_pkg::xlen{sel_exe_bit}} & held_ex_data)
                 | ({wb_pkg::xlen{sel_mem_bit}} & held_mem_data)
                 | ({wb_pkg::xlen{sel_csr_bit}} & held_csr_data);

  // x0 writes are dropped here so forwarding never sees them
  assign wr_en   = retire && held_wen && (held_wdest != '0);
  assign wr_addr = held_wdest;

  // decode upstream must never merge two sources
  always_comb begin
    a_sel_onehot: assert final (!retire || $onehot0(held_wr_sel))
      else $error("write select not one-hot at retire: %b", held_wr_sel);
  end

endmodule

// File: hw/regfile.sv
// 32 x 64 register file, x0 hard zero, two read ports with write bypass
`timescale 1ns/10ps

module regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_en,
  input  logic [wb_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [wb_pkg::xlen-1:0]       wr_data,
  input  logic [wb_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [wb_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [wb_pkg::xlen-1:0]       rs1_data,
  output logic [wb_pkg::xlen-1:0]       rs2_data
);

  // x0 has no storage
  logic [wb_pkg::xlen-1:0] regs [1:wb_pkg::reg_count-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < wb_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // shared read logic, retiring write wins over the stored value
  function automatic logic [wb_pkg::xlen-1:0] read_port(
    input logic [wb_pkg::reg_addr_w-1:0] addr
  );
    logic [wb_pkg::xlen-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (wr_en && (wr_addr == addr)) begin
      value = wr_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
  end

  always_comb begin
    rs2_data = read_port(rs2_addr);
  end

endmodule

// File: hw/commit_port.sv
// commit trace registers, retire counter and serial character output
`timescale 1ns/10ps

module commit_port (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      retire,
  input  logic [wb_pkg::xlen-1:0]   held_pc,
  input  logic [wb_pkg::inst_w-1:0] held_inst,
  input  logic                      held_uart_valid,
  input  logic [wb_pkg::char_w-1:0] held_uart_char,
  input  logic                      held_valid,
  input  logic                      uart_ready,
  output logic                      commit_valid,
  output logic [wb_pkg::xlen-1:0]   commit_pc,
  output logic [wb_pkg::inst_w-1:0] commit_inst,
  output logic [wb_pkg::cnt_w-1:0]  retire_count,
  output logic                      uart_valid,
  output logic [wb_pkg::char_w-1:0] uart_char
);

  // one-cycle commit pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= retire;
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      commit_pc   <= held_pc;
      commit_inst <= held_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_count <= '0;
    end else if (retire) begin
      retire_count <= retire_count + 1'b1;
    end
  end

  // character is offered straight from the held item,
  // the latch keeps it there until the sink takes it
  assign uart_valid = held_valid && held_uart_valid;
  assign uart_char  = held_uart_char;

  // no drop and no change of an offered character before the transfer
  a_uart_stable: assert property (@(posedge clk) disable iff (rst)
    uart_valid && !uart_ready |=> uart_valid && $stable(uart_char));

endmodule

// File: hw/wb_top.sv
// write-back top: latch, source select, register file and commit port
`timescale 1ns/10ps

module wb_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [wb_pkg::xlen-1:0]       in_pc,
  input  logic [wb_pkg::inst_w-1:0]     in_inst,
  input  logic                          in_wen,
  input  logic [wb_pkg::reg_addr_w-1:0] in_wdest,
  input  logic [wb_pkg::sel_w-1:0]      in_wr_sel,
  input  logic [wb_pkg::xlen-1:0]       in_ex_data,
  input  logic [wb_pkg::xlen-1:0]       in_mem_data,
  input  logic [wb_pkg::xlen-1:0]       in_csr_data,
  input  logic                          in_uart_valid,
  input  logic [wb_pkg::char_w-1:0]     in_uart_char,
  input  logic                          uart_ready,
  input  logic [wb_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [wb_pkg::reg_addr_w-1:0] rs2_addr,
  output logic                          allowin,
  output logic [wb_pkg::xlen-1:0]       rs1_data,
  output logic [wb_pkg::xlen-1:0]       rs2_data,
  output logic                          fwd_valid,
  output logic [wb_pkg::reg_addr_w-1:0] fwd_addr,
  output logic [wb_pkg::xlen-1:0]       fwd_data,
  output logic                          commit_valid,
  output logic [wb_pkg::xlen-1:0]       commit_pc,
  output logic [wb_pkg::inst_w-1:0]     commit_inst,
  output logic [wb_pkg::cnt_w-1:0]      retire_count,
  output logic                          uart_valid,
  output logic [wb_pkg::char_w-1:0]     uart_char
);

  logic                          held_valid;
  logic                          retire;
  logic [wb_pkg::xlen-1:0]       held_pc;
  logic [wb_pkg::inst_w-1:0]     held_inst;
  logic                          held_wen;
  logic [wb_pkg::reg_addr_w-1:0] held_wdest;
  logic [wb_pkg::sel_w-1:0]      held_wr_sel;
  logic [wb_pkg::xlen-1:0]       held_ex_data;
  logic [wb_pkg::xlen-1:0]       held_mem_data;
  logic [wb_pkg::xlen-1:0]       held_csr_data;
  logic                          held_uart_valid;
  logic [wb_pkg::char_w-1:0]     held_uart_char;

  wb_latch u_latch (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (in_valid),
    .in_pc           (in_pc),
    .in_inst         (in_inst),
    .in_wen          (in_wen),
    .in_wdest        (in_wdest),
    .in_wr_sel       (in_wr_sel),
    .in_ex_data      (in_ex_data),
    .in_mem_data     (in_mem_data),
    .in_csr_data     (in_csr_data),
    .in_uart_valid   (in_uart_valid),
    .in_uart_char    (in_uart_char),
    .uart_ready      (uart_ready),
    .allowin         (allowin),
    .held_valid      (held_valid),
    .retire          (retire),
    .held_pc         (held_pc),
    .held_inst       (held_inst),
    .held_wen        (held_wen),
    .held_wdest      (held_wdest),
    .held_wr_sel     (held_wr_sel),
    .held_ex_data    (held_ex_data),
    .held_mem_data   (held_mem_data),
    .held_csr_data   (held_csr_data),
    .held_uart_valid (held_uart_valid),
    .held_uart_char  (held_uart_char)
  );

  // write port doubles as the forwarding view
  wb_select u_select (
    .held_wen      (held_wen),
    .held_wdest    (held_wdest),
    .held_wr_sel   (held_wr_sel),
    .held_ex_data  (held_ex_data),
    .held_mem_data (held_mem_data),
    .held_csr_data (held_csr_data),
    .retire        (retire),
    .wr_en         (fwd_valid),
    .wr_addr       (fwd_addr),
    .wr_data       (fwd_data)
  );

  regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (fwd_valid),
    .wr_addr  (fwd_addr),
    .wr_data  (fwd_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  commit_port u_commit (
    .clk             (clk),
    .rst             (rst),
    .retire          (retire),
    .held_pc         (held_pc),
    .held_inst       (held_inst),
    .held_uart_valid (held_uart_valid),
    .held_uart_char  (held_uart_char),
    .held_valid      (held_valid),
    .uart_ready      (uart_ready),
    .commit_valid    (commit_valid),
    .commit_pc       (commit_pc),
    .commit_inst     (commit_inst),
    .retire_count    (retire_count),
    .uart_valid      (uart_valid),
    .uart_char       (uart_char)
  );

endmodule

// File: test/tb_checks.svh
// reference register model, compare tasks and the item drive task for the write-back testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// expected architectural state, x0 never written
logic [wb_pkg::xlen-1:0] model [wb_pkg::reg_count];

task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
  $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
  err_count++;
endtask

// one compare per kind of DUT result
task automatic check_data(input string name, input logic [wb_pkg::xlen-1:0] got, exp);
  if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask
task automatic check_addr(input string name, input logic [wb_pkg::reg_addr_w-1:0] got, exp);
  if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask
task automatic check_bit(input string name, input logic got, exp);
  if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask
task automatic check_count(input string name, input logic [wb_pkg::cnt_w-1:0] got, exp);
  if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask
task automatic check_char(input string name, input logic [wb_pkg::char_w-1:0] got, exp);
  if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask
task automatic check_inst(input string name, input logic [wb_pkg::inst_w-1:0] got, exp);
  if (got !== exp) mismatch(name, 64'(got), 64'(exp));
endtask

// present one item at the falling edge and hold it until the stage takes it
task automatic drive_item(
  input logic [wb_pkg::xlen-1:0]       pc,
  input logic [wb_pkg::inst_w-1:0]     inst,
  input logic                          wen,
  input logic [wb_pkg::reg_addr_w-1:0] wdest,
  input logic [wb_pkg::sel_w-1:0]      sel,
  input logic [wb_pkg::xlen-1:0]       ex, mem, csr,
  input logic                          uv,
  input logic [wb_pkg::char_w-1:0]     uc
);
  in_valid = 1'b1;
  {in_pc, in_inst, in_wen, in_wdest, in_wr_sel} = {pc, inst, wen, wdest, sel};
  {in_ex_data, in_mem_data, in_csr_data, in_uart_valid, in_uart_char} = {ex, mem, csr, uv, uc};
  do tick(); while (!took);
  in_valid = 1'b0;
  // items retire in order, so the model can move on at acceptance
  if (wen && wdest != '0)
    model[wdest] = sel == 3'b001 ? ex : sel == 3'b010 ? mem : sel == 3'b100 ? csr : 64'h0;
  if (uv)
    sent_q.push_back(uc);
endtask

`endif

// File: test/tb_wb_top.sv
// clock, reset, watchdog, LFSR stimulus and directed tests for the write-back stage
`timescale 1ns/10ps

module tb_wb_top;

  // upper bound on items over the directed tests and the random stream
  localparam int item_total = 220;

  logic                          clk, rst, in_valid, in_wen, in_uart_valid, uart_ready;
  logic [wb_pkg::xlen-1:0]       in_pc, in_ex_data, in_mem_data, in_csr_data;
  logic [wb_pkg::inst_w-1:0]     in_inst;
  logic [wb_pkg::reg_addr_w-1:0] in_wdest, rs1_addr, rs2_addr;
  logic [wb_pkg::sel_w-1:0]      in_wr_sel;
  logic [wb_pkg::char_w-1:0]     in_uart_char;
  logic                          allowin, fwd_valid, commit_valid, uart_valid;
  logic [wb_pkg::xlen-1:0]       rs1_data, rs2_data, fwd_data, commit_pc;
  logic [wb_pkg::reg_addr_w-1:0] fwd_addr;
  logic [wb_pkg::inst_w-1:0]     commit_inst;
  logic [wb_pkg::cnt_w-1:0]      retire_count;
  logic [wb_pkg::char_w-1:0]     uart_char;

  logic [15:0]               lfsr;
  logic                      took, ready_rand;
  logic [wb_pkg::char_w-1:0] sent_q[$], rx_q[$];
  int                        err_count, test_err, ok_tests, bad_tests;

  wb_top UUT (.*);

  always #5 clk = ~clk;

  `include "tb_checks.svh"

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // one cycle from the falling edge with sampling 1 ns after the inputs settle
  task automatic tick();
    logic [63:0] r;
    if (ready_rand) begin
      rand_bits(1, r);
      uart_ready = r[0];
    end
    #1;
    took = in_valid && allowin;
    if (uart_valid && uart_ready)
      rx_q.push_back(uart_char);
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic read_check(input logic [4:0] a, input logic [63:0] ea,
                            input logic [4:0] b, input logic [63:0] eb);
    rs1_addr = a;
    rs2_addr = b;
    #1;
    check_data("rs1_data", rs1_data, ea);
    check_data("rs2_data", rs2_data, eb);
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_err) begin
      ok_tests++;
      $display("%s: ok", name);
    end else begin
      bad_tests++;
      $display("%s: %0d errors", name, err_count - test_err);
    end
    test_err = err_count;
  endtask

  task automatic reset_state();
    check_bit("commit_valid", commit_valid, 1'b0);
    check_bit("uart_valid", uart_valid, 1'b0);
    check_bit("fwd_valid", fwd_valid, 1'b0);
    check_bit("allowin", allowin, 1'b1);
    check_count("retire_count", retire_count, '0);
    for (int i = 0; i < 32; i += 8) begin
      read_check(5'(i), '0, 5'(i + 3), '0);
      tick();
    end
    finish_test("reset_state");
  endtask

  // exe, mem and csr select followed by an empty select that clears x5
  task automatic source_select();
    logic [wb_pkg::xlen-1:0] v [4];
    for (int i = 0; i < 3; i++)
      rand_bits(64, v[i]);
    // an empty select writes zero
    v[3] = '0;
    for (int i = 0; i < 4; i++) begin
      // x5 still holds the execute result before the empty select
      if (i == 3)
        read_check(5'd5, v[0], 5'd6, v[1]);
      drive_item(64'h1000 + 64'(4 * i), 32'h0000_0013, 1'b1, i < 3 ? 5'(5 + i) : 5'd5,
                 i < 3 ? 3'(1 << i) : 3'b000, v[0], v[1], v[2], 1'b0, 8'h00);
      check_bit("fwd_valid", fwd_valid, 1'b1);
      check_addr("fwd_addr", fwd_addr, i < 3 ? 5'(5 + i) : 5'd5);
      check_data("fwd_data", fwd_data, v[i]);
    end
    tick();
    read_check(5'd5, v[3], 5'd6, v[1]);
    tick();
    read_check(5'd7, v[2], 5'd7, v[2]);
    tick();
    finish_test("write_source_select");
  endtask

  // two x0 targets and a disabled write to x6
  task automatic ignored_writes();
    logic [wb_pkg::cnt_w-1:0] base;
    logic [wb_pkg::xlen-1:0]  keep;
    base = retire_count;
    keep = model[6];
    for (int i = 0; i < 3; i++) begin
      drive_item(64'h2000 + 64'(4 * i), 32'h0010_0093 + 32'(i), i != 2, i != 2 ? 5'd0 : 5'd6,
                 3'b001, 64'hdead_beef_0000_0000 + 64'(i), '0, '0, 1'b0, 8'h00);
      check_bit("fwd_valid", fwd_valid, 1'b0);
      tick();
      check_bit("commit_valid", commit_valid, 1'b1);
      check_data("commit_pc", commit_pc, 64'h2000 + 64'(4 * i));
      check_inst("commit_inst", commit_inst, 32'h0010_0093 + 32'(i));
      check_count("retire_count", retire_count, base + 64'(i + 1));
    end
    read_check(5'd0, '0, 5'd6, keep);
    tick();
    finish_test("x0_and_disabled_writes");
  endtask

  task automatic serial_stall();
    logic [wb_pkg::cnt_w-1:0] base;
    logic [wb_pkg::xlen-1:0]  old, v;
    int                       rx_before;
    rand_bits(64, v);
    base = retire_count;
    old = model[10];
    rx_before = rx_q.size();
    uart_ready = 1'b0;
    drive_item(64'h3000, 32'h0000_0073, 1'b1, 5'd10, 3'b010, '0, v, '0, 1'b1, 8'h41);
    repeat (5) begin
      check_bit("allowin", allowin, 1'b0);
      check_bit("uart_valid", uart_valid, 1'b1);
      check_char("uart_char", uart_char, 8'h41);
      read_check(5'd10, old, 5'd10, old);
      tick();
    end
    uart_ready = 1'b1;
    tick();
    tick();
    check_count("received characters", 64'(rx_q.size()), 64'(rx_before + 1));
    check_char("received char", rx_q[$], 8'h41);
    check_count("retire_count", retire_count, base + 64'd1);
    check_bit("uart_valid", uart_valid, 1'b0);
    read_check(5'd10, v, 5'd10, v);
    tick();
    finish_test("serial_backpressure");
  endtask

  task automatic read_bypass();
    logic [wb_pkg::xlen-1:0] old, v;
    rand_bits(64, v);
    old = model[12];
    drive_item(64'h4000, 32'h0000_0033, 1'b1, 5'd12, 3'b001, v, '0, '0, 1'b0, 8'h00);
    // storage still holds the previous value while the item retires
    check_data("regs[12]", UUT.u_regfile.regs[12], old);
    read_check(5'd12, v, 5'd12, v);
    tick();
    read_check(5'd12, v, 5'd3, model[3]);
    tick();
    finish_test("write_back_bypass");
  endtask

  task automatic random_stream();
    logic [63:0]              pc, ex, mem, csr, f;
    logic [wb_pkg::sel_w-1:0] sel;
    logic [wb_pkg::cnt_w-1:0] base;
    base = retire_count;
    ready_rand = 1'b1;
    for (int n = 0; n < 200; n++) begin
      rand_bits(64, pc);
      rand_bits(64, ex);
      rand_bits(64, mem);
      rand_bits(64, csr);
      rand_bits(49, f);
      sel = f[39:38] == 2'd0 ? 3'b000 : 3'(1 << (f[39:38] - 2'd1));
      drive_item(pc, f[31:0], f[32], f[37:33], sel, ex, mem, csr, f[40], f[48:41]);
    end
    ready_rand = 1'b0;
    uart_ready = 1'b1;
    for (int k = 0; k < 20 && retire_count != base + 64'd200; k++)
      tick();
    check_count("retire_count", retire_count, base + 64'd200);
    for (int i = 0; i < 32; i += 2) begin
      read_check(5'(i), model[i], 5'(i + 1), model[i + 1]);
      tick();
    end
    check_count("received characters", 64'(rx_q.size()), 64'(sent_q.size()));
    for (int i = 0; i < sent_q.size() && i < rx_q.size(); i++)
      check_char("received char", rx_q[i], sent_q[i]);
    finish_test("random_stream");
  endtask

  // up to 20 cycles per item plus reset and the read-back sweeps
  initial begin
    repeat (item_total * 20 + 200) @(posedge clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    {in_pc, in_inst, in_wen, in_wdest, in_wr_sel} = '0;
    {in_ex_data, in_mem_data, in_csr_data, in_uart_valid, in_uart_char} = '0;
    uart_ready = 1'b1;
    rs1_addr = '0;
    rs2_addr = '0;
    lfsr = 16'd48167;
    ready_rand = 1'b0;
    took = 1'b0;
    for (int i = 0; i < 32; i++)
      model[i] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_state();
    source_select();
    ignored_writes();
    serial_stall();
    read_bypass();
    random_stream();
    $display("summary: %0d tests ok, %0d tests with errors, %0d failed checks",
             ok_tests, bad_tests, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+test
hw/wb_pkg.sv
hw/wb_latch.sv
hw/wb_select.sv
hw/regfile.sv
hw/commit_port.sv
hw/wb_top.sv
test/tb_wb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the simulation output
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module tb_wb_top -f compile.f -o tb_wb_top &&
  ./obj_dir/tb_wb_top | tee /dev/stderr | grep -q "Test passed" &&
  echo "run.sh: simulation ok" ||
  { echo "run.sh: simulation FAILED"; exit 1; }
